//--- tb.f
+incdir+dv
source/gat_types_pkg.sv
source/gat_debug_pkg.sv
source/wh_proj.sv
source/attn_act.sv
source/neighbor_aggr.sv
source/gat_monitor.sv
source/gat_layer_top.sv
dv/gat_tb.sv

//--- dv/gat_vectors.svh
`ifndef GAT_VECTORS_SVH
`define GAT_VECTORS_SVH

localparam int NUM_EDGES   = 17;
localparam int NUM_RES     = 8;
localparam int FLUSH_EDGES = 3; // Fills the pipeline while the output is stalled.
localparam int SHORT_EDGES = 4; // Replayed after the mid-run reset.
localparam int SHORT_RES   = 4;

// Columns are node, last, then features packed as {f3, f2, f1, f0}.
// Feature fi meets WEIGHTS[i], so the projection is 3*f0 - 2*f1 + 5*f2 + f3.
localparam gat_types_pkg::edge_t EDGE_TAB [NUM_EDGES] = '{
  '{node: 10'd1, last: 1'b1, feat: {8'sd7, 8'sd4, 8'sd2, 8'sd10}},
  '{node: 10'd2, last: 1'b1, feat: {8'sd1, -8'sd3, 8'sd5, -8'sd10}},
  '{node: 10'd3, last: 1'b1, feat: {8'sd127, 8'sd127, 8'h80, 8'sd127}},
  '{node: 10'd4, last: 1'b1, feat: {8'h80, 8'h80, 8'sd127, 8'h80}},
  '{node: 10'd5, last: 1'b0, feat: {8'sd0, 8'sd2, 8'sd1, 8'sd4}},
  '{node: 10'd5, last: 1'b0, feat: {-8'sd2, 8'sd0, 8'sd3, -8'sd6}},
  '{node: 10'd5, last: 1'b1, feat: {8'sd1, 8'sd1, 8'sd1, 8'sd1}},
  '{node: 10'd6, last: 1'b0, feat: {8'sd0, 8'sd0, 8'sd0, 8'sd1}},
  '{node: 10'd6, last: 1'b0, feat: {8'sd0, 8'sd0, 8'sd1, 8'sd0}},
  '{node: 10'd6, last: 1'b0, feat: {8'sd0, 8'sd1, 8'sd0, 8'sd0}},
  '{node: 10'd6, last: 1'b0, feat: {-8'sd8, 8'sd0, 8'sd0, 8'sd0}},
  '{node: 10'd6, last: 1'b0, feat: {8'sd0, 8'sd0, 8'sd0, 8'sd20}},
  '{node: 10'd6, last: 1'b1, feat: {8'sd0, 8'sd0, 8'sd0, -8'sd20}},
  '{node: 10'd5, last: 1'b0, feat: {8'sd0, 8'sd0, 8'sd50, 8'sd0}},
  '{node: 10'd5, last: 1'b1, feat: {8'sd0, -8'sd9, 8'sd0, 8'sd0}},
  '{node: 10'd7, last: 1'b0, feat: {8'sd5, 8'sd5, 8'sd5, 8'sd5}},
  '{node: 10'd7, last: 1'b1, feat: {-8'sd1, 8'sd3, 8'sd0, 8'sd2}}
};

// Negative projections are shifted right by 3 with floor rounding before the per-node sum.
localparam gat_types_pkg::node_res_t EXP_TAB [NUM_RES] = '{
  '{node: 10'd1, sum: 24'sd53,   cnt: 8'd1},
  '{node: 10'd2, sum: -24'sd7,   cnt: 8'd1},
  '{node: 10'd3, sum: 24'sd1399, cnt: 8'd1},
  '{node: 10'd4, sum: -24'sd176, cnt: 8'd1},
  '{node: 10'd5, sum: 24'sd23,   cnt: 8'd3},
  '{node: 10'd6, sum: 24'sd58,   cnt: 8'd6},
  '{node: 10'd5, sum: -24'sd19,  cnt: 8'd2},
  '{node: 10'd7, sum: 24'sd55,   cnt: 8'd2}
};

string res_name [NUM_RES] = '{
  "single positive", "single negative", "max positive", "max negative",
  "mixed sign node 5", "six edge node", "repeat node 5", "two edge node"
};

`endif

//--- dv/gat_tb.sv
`timescale 1ns/10ps
`default_nettype none

module gat_tb;

  `include "gat_vectors.svh"

  localparam int TIMEOUT_CYCLES = 20 * (NUM_EDGES + FLUSH_EDGES + SHORT_EDGES) + 200;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                                clk = 1'b0;
  logic                                rst_n;
  logic                                edge_valid;
  logic                                edge_ready;
  gat_types_pkg::edge_t                edge_in;
  logic                                res_valid;
  logic                                res_ready;
  gat_types_pkg::node_res_t            res;
  logic [gat_debug_pkg::DBG_W-1:0]     debug_status;
  logic [gat_debug_pkg::DBG_W-1:0]     debug_count;
  logic [gat_debug_pkg::DBG_W-1:0]     debug_capture;

  logic                                stall_out; // Forces res_ready low when set.
  logic [31:0]                         lfsr;
  int                                  exp_idx;
  int                                  exp_limit;
  int                                  pass_cnt;
  int                                  fail_cnt;
  int                                  cycle_cnt;
  logic                                hold_pend;
  gat_types_pkg::node_res_t            hold_res;

  gat_layer_top DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .edge_valid_i    (edge_valid),
    .edge_ready_o    (edge_ready),
    .edge_i          (edge_in),
    .res_valid_o     (res_valid),
    .res_ready_i     (res_ready),
    .res_o           (res),
    .debug_status_o  (debug_status),
    .debug_count_o   (debug_count),
    .debug_capture_o (debug_capture)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // Returns the capture word expected after the first n results.
  // It holds the last node 5 sum, sign-extended.
  function automatic logic [gat_debug_pkg::DBG_W-1:0] last_capture_sum(input int n);
    logic [gat_debug_pkg::DBG_W-1:0] word;
    word = '0;
    for (int i = 0; i < n; i++) begin
      if (EXP_TAB[i].node == gat_debug_pkg::CAPTURE_NODE) begin
        word = gat_debug_pkg::DBG_W'($signed(EXP_TAB[i].sum));
      end
    end
    return word;
  endfunction

  task automatic check_res(input string name, input gat_types_pkg::node_res_t exp_res,
                           input gat_types_pkg::node_res_t act_res);
    if (act_res === exp_res) begin
      pass_cnt++;
      $display("Pass %s: node=%0d sum=%0d cnt=%0d", name, act_res.node,
               $signed(act_res.sum), act_res.cnt);
    end else begin
      fail_cnt++;
      $display("Fail %s: expected node=%0d sum=%0d cnt=%0d, actual node=%0d sum=%0d cnt=%0d",
               name, exp_res.node, $signed(exp_res.sum), exp_res.cnt,
               act_res.node, $signed(act_res.sum), act_res.cnt);
    end
  endtask

  task automatic check_word(input string name, input logic [gat_debug_pkg::DBG_W-1:0] exp_w,
                            input logic [gat_debug_pkg::DBG_W-1:0] act_w);
    if (act_w === exp_w) begin
      pass_cnt++;
      $display("Pass %s: 0x%08h", name, act_w);
    end else begin
      fail_cnt++;
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp_w, act_w);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_f, input logic act_f);
    if (act_f === exp_f) begin
      pass_cnt++;
      $display("Pass %s: %b", name, act_f);
    end else begin
      fail_cnt++;
      $display("Fail %s: expected %b, actual %b", name, exp_f, act_f);
    end
  endtask

  // Holds the edge until a rising edge sees the DUT ready.
  task automatic send_edge(input gat_types_pkg::edge_t e);
    @(negedge clk);
    edge_valid = 1'b1;
    edge_in    = e;
    @(posedge clk);
    while (!edge_ready) @(posedge clk);
  endtask

  task automatic idle_input();
    @(negedge clk);
    edge_valid = 1'b0;
    edge_in    = '0;
  endtask

  task automatic wait_results(input int n);
    while (exp_idx < n) @(negedge clk);
  endtask

  initial begin
    res_ready = 1'b0;
    lfsr      = 32'h2799;
    forever begin
      @(negedge clk);
      if (stall_out) begin
        res_ready = 1'b0;
      end else begin
        res_ready = lfsr[0];
        lfsr      = lfsr_step(lfsr); // One step per bit taken.
      end
    end
  end

  // Output scoreboard. Also checks that a stalled result holds still.
  always @(posedge clk) begin
    if (!rst_n) begin
      hold_pend = 1'b0;
    end else begin
      if (hold_pend && !res_valid) begin
        fail_cnt++;
        $display("Error: res_valid dropped before the result was taken");
      end else if (hold_pend && res !== hold_res) begin
        fail_cnt++;
        $display("Error: result payload changed while the output was stalled");
      end
      if (res_valid && res_ready) begin
        if (exp_idx < exp_limit) begin
          check_res(res_name[exp_idx], EXP_TAB[exp_idx], res);
          exp_idx++;
        end else begin
          fail_cnt++;
          $display("Error: extra result for node %0d beyond the table", res.node);
        end
      end
      hold_pend = res_valid && !res_ready;
      hold_res  = res;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: results missing after %0d cycles", cycle_cnt);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    edge_valid = 1'b0;
    edge_in    = '0;
    stall_out  = 1'b0;
    exp_idx    = 0;
    exp_limit  = NUM_RES;
    pass_cnt   = 0;
    fail_cnt   = 0;
    hold_pend  = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    check_flag("idle res_valid", 1'b0, res_valid);
    check_flag("idle edge_ready", 1'b1, edge_ready);
    check_word("idle debug status", '0, debug_status);
    check_word("idle debug count", '0, debug_count);
    check_word("idle debug capture", '0, debug_capture);

    for (int i = 0; i < NUM_EDGES; i++) begin
      send_edge(EDGE_TAB[i]);
    end
    idle_input();
    wait_results(NUM_RES);
    check_flag("drained res_valid", 1'b0, res_valid);
    check_word("debug count", gat_debug_pkg::DBG_W'(NUM_RES), debug_count);
    check_word("debug status", 32'h0000_00ff, debug_status);
    check_word("debug capture", last_capture_sum(NUM_RES), debug_capture);

    // Park results inside the pipeline, then reset with them still in flight.
    @(posedge clk);
    stall_out = 1'b1;
    for (int i = 0; i < FLUSH_EDGES; i++) begin
      send_edge(EDGE_TAB[i]);
    end
    idle_input();
    while (!res_valid) @(negedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    check_flag("reset res_valid", 1'b0, res_valid);
    check_word("reset debug status", '0, debug_status);
    check_word("reset debug count", '0, debug_count);
    check_word("reset debug capture", '0, debug_capture);
    exp_idx   = 0;
    exp_limit = SHORT_RES;
    rst_n     = 1'b1;
    @(posedge clk);
    stall_out = 1'b0;

    for (int i = 0; i < SHORT_EDGES; i++) begin
      send_edge(EDGE_TAB[i]);
    end
    idle_input();
    wait_results(SHORT_RES);
    check_flag("replay drained res_valid", 1'b0, res_valid);
    check_word("replay debug count", gat_debug_pkg::DBG_W'(SHORT_RES), debug_count);
    check_word("replay debug capture", last_capture_sum(SHORT_RES), debug_capture);

    $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/gat_layer_top.sv
`timescale 1ns/10ps
`default_nettype none

module gat_layer_top (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                edge_valid_i,
  output logic                               edge_ready_o,
  input  gat_types_pkg::edge_t               edge_i,
  output logic                               res_valid_o,
  input  wire                                res_ready_i,
  output gat_types_pkg::node_res_t           res_o,
  output logic [gat_debug_pkg::DBG_W-1:0]    debug_status_o,
  output logic [gat_debug_pkg::DBG_W-1:0]    debug_count_o,
  output logic [gat_debug_pkg::DBG_W-1:0]    debug_capture_o
);

  gat_types_pkg::proj_t                proj;
  logic                                proj_valid;
  logic                                proj_ready;
  gat_types_pkg::score_t               score;
  logic                                score_valid;
  logic                                score_ready;
  logic [gat_debug_pkg::NUM_STG-1:0]   link_valid;
  logic [gat_debug_pkg::NUM_STG-1:0]   link_ready;
  gat_debug_pkg::dbg_status_t          mon_status;

  wh_proj u_wh_proj (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (edge_valid_i),
    .in_ready_o  (edge_ready_o),
    .in_edge_i   (edge_i),
    .out_valid_o (proj_valid),
    .out_ready_i (proj_ready),
    .out_proj_o  (proj)
  );

  attn_act u_attn_act (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (proj_valid),
    .in_ready_o  (proj_ready),
    .in_proj_i   (proj),
    .out_valid_o (score_valid),
    .out_ready_i (score_ready),
    .out_score_o (score)
  );

  neighbor_aggr u_neighbor_aggr (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (score_valid),
    .in_ready_o  (score_ready),
    .in_score_i  (score),
    .out_valid_o (res_valid_o),
    .out_ready_i (res_ready_i),
    .out_res_o   (res_o)
  );

  // Link vectors are indexed by the stage enum.
  assign link_valid[gat_debug_pkg::STG_IN]   = edge_valid_i;
  assign link_ready[gat_debug_pkg::STG_IN]   = edge_ready_o;
  assign link_valid[gat_debug_pkg::STG_PROJ] = proj_valid;
  assign link_ready[gat_debug_pkg::STG_PROJ] = proj_ready;
  assign link_valid[gat_debug_pkg::STG_ACT]  = score_valid;
  assign link_ready[gat_debug_pkg::STG_ACT]  = score_ready;
  assign link_valid[gat_debug_pkg::STG_OUT]  = res_valid_o;
  assign link_ready[gat_debug_pkg::STG_OUT]  = res_ready_i;

  gat_monitor u_gat_monitor (
    .clk             (clk),
    .rst_n           (rst_n),
    .link_valid_i    (link_valid),
    .link_ready_i    (link_ready),
    .res_i           (res_o),
    .debug_status_o  (mon_status),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

  assign debug_status_o = gat_debug_pkg::DBG_W'(mon_status); // Zero-extended.

endmodule

`default_nettype wire

//--- source/gat_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module gat_monitor (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  wire  [gat_debug_pkg::NUM_STG-1:0]        link_valid_i,
  input  wire  [gat_debug_pkg::NUM_STG-1:0]        link_ready_i,
  input  gat_types_pkg::node_res_t                 res_i,
  output gat_debug_pkg::dbg_status_t               debug_status_o,
  output logic [gat_debug_pkg::DBG_W-1:0]          debug_count_o,
  output logic [gat_debug_pkg::DBG_W-1:0]          debug_capture_o
);

  gat_debug_pkg::dbg_status_t             status_q;
  logic [gat_types_pkg::CNT_W-1:0]        node_cnt_q;
  logic signed [gat_types_pkg::SUM_W-1:0] capture_q;
  logic                                   out_xfer;
  logic                                   capture_hit;

  assign out_xfer    = link_valid_i[gat_debug_pkg::STG_OUT] &&
                       link_ready_i[gat_debug_pkg::STG_OUT];
  assign capture_hit = out_xfer && (res_i.node == gat_types_pkg::NODE_W'(gat_debug_pkg::CAPTURE_NODE));

  // Sticky flags. Once a link has shown valid or ready, the bit stays.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
    end else begin
      status_q.vld_seen <= status_q.vld_seen | link_valid_i;
      status_q.rdy_seen <= status_q.rdy_seen | link_ready_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_cnt_q <= '0;
    end else if (out_xfer) begin
      node_cnt_q <= node_cnt_q + 1'b1; // Wraps after 255 results.
    end
  end

  // Keeps the most recent sum seen for the capture node.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      capture_q <= '0;
    end else if (capture_hit) begin
      capture_q <= res_i.sum;
    end
  end

  assign debug_status_o  = status_q;
  assign debug_count_o   = gat_debug_pkg::DBG_W'(node_cnt_q);
  assign debug_capture_o = gat_debug_pkg::DBG_W'(capture_q); // Sign-extended.

endmodule

`default_nettype wire

//--- source/neighbor_aggr.sv
`timescale 1ns/10ps
`default_nettype none

module neighbor_aggr (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        in_valid_i,
  output logic                       in_ready_o,
  input  gat_types_pkg::score_t      in_score_i,
  output logic                       out_valid_o,
  input  wire                        out_ready_i,
  output gat_types_pkg::node_res_t   out_res_o
);

  logic signed [gat_types_pkg::SUM_W-1:0] acc_sum;
  logic        [gat_types_pkg::CNT_W-1:0] acc_cnt;
  logic signed [gat_types_pkg::SUM_W-1:0] sum_next;
  logic        [gat_types_pkg::CNT_W-1:0] cnt_next;
  logic                                   accept;
  logic                                   close_node;

  // Only one result may be pending, so every score waits for a free slot.
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;
  assign close_node = accept && in_score_i.last;

  // Running totals including the edge on the input this cycle.
  assign sum_next = acc_sum + $signed(in_score_i.score);
  assign cnt_next = acc_cnt + 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_sum <= '0;
      acc_cnt <= '0;
    end else if (close_node) begin
      acc_sum <= '0; // Next node starts from zero.
      acc_cnt <= '0;
    end else if (accept) begin
      acc_sum <= sum_next;
      acc_cnt <= cnt_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else if (close_node) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (close_node) begin
      out_res_o.node <= in_score_i.node;
      out_res_o.sum  <= sum_next;
      out_res_o.cnt  <= cnt_next;
    end
  end

endmodule

`default_nettype wire

//--- source/attn_act.sv
`timescale 1ns/10ps
`default_nettype none

module attn_act (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        in_valid_i,
  output logic                       in_ready_o,
  input  gat_types_pkg::proj_t       in_proj_i,
  output logic                       out_valid_o,
  input  wire                        out_ready_i,
  output gat_types_pkg::score_t      out_score_o
);

  logic signed [gat_types_pkg::WH_W-1:0] act;
  logic                                  accept;

  // Leaky ReLU. Negative scores are scaled by 1/8 with the sign kept.
  always_comb begin
    if (in_proj_i.wh[gat_types_pkg::WH_W-1]) begin
      act = $signed(in_proj_i.wh) >>> gat_types_pkg::LEAK_SHIFT;
    end else begin
      act = in_proj_i.wh;
    end
  end

  assign in_ready_o = !out_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else if (accept) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_score_o.node  <= in_proj_i.node;
      out_score_o.last  <= in_proj_i.last;
      out_score_o.score <= act;
    end
  end

endmodule

`default_nettype wire

//--- source/wh_proj.sv
`timescale 1ns/10ps
`default_nettype none

module wh_proj (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        in_valid_i,
  output logic                       in_ready_o,
  input  gat_types_pkg::edge_t       in_edge_i,
  output logic                       out_valid_o,
  input  wire                        out_ready_i,
  output gat_types_pkg::proj_t       out_proj_o
);

  logic signed [gat_types_pkg::WH_W-1:0] dot;
  logic                                  accept;

  // Each product is formed at WH_W bits, so no partial sum can overflow.
  always_comb begin
    dot = '0;
    for (int i = 0; i < gat_types_pkg::NUM_FEAT; i++) begin
      dot = dot + $signed(in_edge_i.feat[i]) * $signed(gat_types_pkg::WEIGHTS[i]);
    end
  end

  assign in_ready_o = !out_valid_o || out_ready_i; // Empty, or draining this cycle.
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else if (accept) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_proj_o.node <= in_edge_i.node;
      out_proj_o.last <= in_edge_i.last;
      out_proj_o.wh   <= dot;
    end
  end

endmodule

`default_nettype wire

//--- source/gat_debug_pkg.sv
`default_nettype none

package gat_debug_pkg;

  localparam int NUM_STG = 4;
  localparam int DBG_W   = 32;

  // Node whose score sum is latched into the capture word.
  localparam int CAPTURE_NODE = 5;

  // Watched link boundaries, in pipeline order.
  typedef enum logic [1:0] {
    STG_IN   = 2'd0,
    STG_PROJ = 2'd1,
    STG_ACT  = 2'd2,
    STG_OUT  = 2'd3
  } stage_e;

  // Boundary s owns the pair vld_seen[s] and rdy_seen[s].
  typedef struct packed {
    logic [NUM_STG-1:0] vld_seen;
    logic [NUM_STG-1:0] rdy_seen;
  } dbg_status_t;

endpackage

`default_nettype wire

//--- source/gat_types_pkg.sv
`default_nettype none

package gat_types_pkg;

  localparam int NUM_FEAT   = 4;
  localparam int FEAT_W     = 8;
  localparam int WH_W       = 18; // Holds 4 x 127 x 128 with sign.
  localparam int SUM_W      = 24;
  localparam int NODE_W     = 10;
  localparam int CNT_W      = 8;
  localparam int LEAK_SHIFT = 3;

  // Element 0 sits in the low byte, so WEIGHTS[0] is 3.
  localparam logic [NUM_FEAT-1:0][FEAT_W-1:0] WEIGHTS = {
    8'sd1, 8'sd5, -8'sd2, 8'sd3
  };

  // One incoming edge. The last flag closes the destination node.
  typedef struct packed {
    logic [NODE_W-1:0]                  node;
    logic                               last;
    logic [NUM_FEAT-1:0][FEAT_W-1:0]    feat;
  } edge_t;

  typedef struct packed {
    logic [NODE_W-1:0]        node;
    logic                     last;
    logic signed [WH_W-1:0]   wh;
  } proj_t;

  typedef struct packed {
    logic [NODE_W-1:0]        node;
    logic                     last;
    logic signed [WH_W-1:0]   score;
  } score_t;

  // One result per destination node.
  typedef struct packed {
    logic [NODE_W-1:0]        node;
    logic signed [SUM_W-1:0]  sum;
    logic [CNT_W-1:0]         cnt;
  } node_res_t;

endpackage

`default_nettype wire
